// ==== Makefile ====
SIM      = verilator
VFLAGS   = --binary --timing --assert
TOP      = tb_issue_queue
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== project.f ====
rtl/rv_isa_pkg.sv
rtl/iq_cfg_pkg.sv
rtl/rs_write_if.sv
rtl/op_decoder.sv
rtl/dispatch_ctrl.sv
rtl/rs_entry_array.sv
rtl/issue_select.sv
rtl/issue_queue_top.sv
testbench/issue_queue_asserts.sv
testbench/tb_issue_queue.sv

// ==== rtl/dispatch_ctrl.sv ====
`timescale 1ns/1ns

module dispatch_ctrl
    import rv_isa_pkg::*;
    import iq_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  dispatch_valid,
    input  op_t                   op,
    input  preg_t                 rs1,
    input  preg_t                 rs2,
    input  preg_t                 rd,
    input  word_t                 rs1_value,
    input  word_t                 rs2_value,
    input  word_t                 imm,
    input  logic [num_pregs-1:0]  reg_ready,
    input  logic [num_fu-1:0]     wb_valid,
    input  preg_t [num_fu-1:0]    wb_tag,
    input  word_t [num_fu-1:0]    wb_value,
    rs_write_if.ctrl              wr,
    output logic                  dispatch_full
);

    logic      do_dispatch;
    logic      free_found;
    slot_idx_t free_idx;
    operand_t  src1_opnd;
    operand_t  src2_opnd;
    rob_no_t   rob_cnt;
    logic      alu_rr;

    ////////////////////
    // free slot search

    assign do_dispatch = dispatch_valid && (op != op_none);

    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!wr.valid[i]) begin
                free_found = 1'b1;
                free_idx   = slot_idx_t'(i);
            end
        end
    end

    ////////////////////
    // operand capture

    // register file first, then a same-cycle broadcast
    function automatic operand_t capture(logic used, preg_t tag, word_t value);
        operand_t opnd;
        opnd.tag   = tag;
        opnd.ready = reg_ready[tag];
        opnd.value = value;
        opnd = wakeup(opnd, wb_valid, wb_tag, wb_value);
        if (!used) begin
            opnd.ready = 1'b1;
            opnd.value = '0;
        end
        return opnd;
    endfunction

    always_comb begin
        src1_opnd = capture(uses_src1(op), rs1, rs1_value);
        src2_opnd = capture(uses_src2(op), rs2, rs2_value);
    end

    assign wr.we           = do_dispatch && free_found;
    assign wr.slot         = free_idx;
    assign wr.entry.op     = op;
    assign wr.entry.rd     = rd;
    assign wr.entry.src1   = src1_opnd;
    assign wr.entry.src2   = src2_opnd;
    assign wr.entry.imm    = imm;
    assign wr.entry.fu     = is_mem_op(op) ? fu_mem : fu_idx_t'(alu_rr);
    assign wr.entry.rob_no = rob_cnt;

    ////////////////////
    // counters and full flag

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rob_cnt       <= '0;
            alu_rr        <= 1'b0;
            dispatch_full <= 1'b0;
        end else begin
            if (wr.we) begin
                rob_cnt <= rob_cnt + 1'b1;
                // memory ops do not move the alu round robin
                if (!is_mem_op(op)) begin
                    alu_rr <= ~alu_rr;
                end
            end
            dispatch_full <= do_dispatch && !free_found;
        end
    end

endmodule

// ==== rtl/iq_cfg_pkg.sv ====
package iq_cfg_pkg;

    import rv_isa_pkg::*;

    localparam int rs_depth  = 8;
    localparam int preg_w    = 6;
    localparam int num_pregs = 64;
    localparam int xlen      = 32;
    localparam int rob_w     = 6;
    localparam int num_fu    = 3;

    typedef logic [$clog2(rs_depth)-1:0] slot_idx_t;
    typedef logic [preg_w-1:0]           preg_t;
    typedef logic [xlen-1:0]             word_t;
    typedef logic [rob_w-1:0]            rob_no_t;
    typedef logic [1:0]                  fu_idx_t;

    // loads and stores only go here
    localparam fu_idx_t fu_mem = 2'd2;

    typedef struct packed {
        preg_t tag;
        logic  ready;
        word_t value;
    } operand_t;

    typedef struct packed {
        op_t      op;
        preg_t    rd;
        operand_t src1;
        operand_t src2;
        word_t    imm;
        fu_idx_t  fu;
        rob_no_t  rob_no;
    } rs_entry_t;

    // tag match against the unit broadcasts, lower unit wins on a tie
    function automatic operand_t wakeup(operand_t opnd, logic [num_fu-1:0] wb_valid,
                                        preg_t [num_fu-1:0] wb_tag,
                                        word_t [num_fu-1:0] wb_value);
        operand_t res;
        res = opnd;
        if (!opnd.ready) begin
            for (int u = num_fu - 1; u >= 0; u--) begin
                if (wb_valid[u] && (wb_tag[u] == opnd.tag)) begin
                    res.ready = 1'b1;
                    res.value = wb_value[u];
                end
            end
        end
        return res;
    endfunction

endpackage

// ==== rtl/issue_queue_top.sv ====
`timescale 1ns/1ns

module issue_queue_top
    import rv_isa_pkg::*;
    import iq_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  dispatch_valid,
    input  logic [6:0]            opcode,
    input  logic [2:0]            funct3,
    input  preg_t                 rs1,
    input  word_t                 rs1_value,
    input  preg_t                 rs2,
    input  word_t                 rs2_value,
    input  preg_t                 rd,
    input  word_t                 imm,
    input  logic [num_pregs-1:0]  reg_ready,
    input  logic [num_fu-1:0]     fu_ready,
    input  logic [num_fu-1:0]     wb_valid,
    input  preg_t [num_fu-1:0]    wb_tag,
    input  word_t [num_fu-1:0]    wb_value,
    output logic [num_fu-1:0]     issue_valid,
    output op_t [num_fu-1:0]      issue_op,
    output preg_t [num_fu-1:0]    issue_rd,
    output word_t [num_fu-1:0]    issue_src1_value,
    output word_t [num_fu-1:0]    issue_src2_value,
    output word_t [num_fu-1:0]    issue_imm,
    output rob_no_t [num_fu-1:0]  issue_rob_no,
    output logic                  dispatch_full
);

    op_t                      op;
    rs_entry_t [rs_depth-1:0] entries;
    logic [rs_depth-1:0]      valid;
    logic [rs_depth-1:0]      clear;

    rs_write_if wr_if ();

    op_decoder op_decoder_i (
        .opcode (opcode),
        .funct3 (funct3),
        .op     (op)
    );

    // writeback lanes feed both capture and wakeup
    dispatch_ctrl dispatch_ctrl_i (
        .clk            (clk),
        .rstn           (rstn),
        .dispatch_valid (dispatch_valid),
        .op             (op),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .imm            (imm),
        .reg_ready      (reg_ready),
        .wb_valid       (wb_valid),
        .wb_tag         (wb_tag),
        .wb_value       (wb_value),
        .wr             (wr_if),
        .dispatch_full  (dispatch_full)
    );

    rs_entry_array rs_entry_array_i (
        .clk      (clk),
        .rstn     (rstn),
        .wr       (wr_if),
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .wb_value (wb_value),
        .clear    (clear),
        .entries  (entries),
        .valid    (valid)
    );

    issue_select issue_select_i (
        .clk              (clk),
        .rstn             (rstn),
        .entries          (entries),
        .valid            (valid),
        .fu_ready         (fu_ready),
        .clear            (clear),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .issue_rd         (issue_rd),
        .issue_src1_value (issue_src1_value),
        .issue_src2_value (issue_src2_value),
        .issue_imm        (issue_imm),
        .issue_rob_no     (issue_rob_no)
    );

endmodule

// ==== rtl/issue_select.sv ====
`timescale 1ns/1ns

module issue_select
    import rv_isa_pkg::*;
    import iq_cfg_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  rs_entry_t [rs_depth-1:0] entries,
    input  logic [rs_depth-1:0]      valid,
    input  logic [num_fu-1:0]        fu_ready,
    output logic [rs_depth-1:0]      clear,
    output logic [num_fu-1:0]        issue_valid,
    output op_t [num_fu-1:0]         issue_op,
    output preg_t [num_fu-1:0]       issue_rd,
    output word_t [num_fu-1:0]       issue_src1_value,
    output word_t [num_fu-1:0]       issue_src2_value,
    output word_t [num_fu-1:0]       issue_imm,
    output rob_no_t [num_fu-1:0]     issue_rob_no
);

    logic [num_fu-1:0]      sel_found;
    slot_idx_t [num_fu-1:0] sel_idx;
    rs_entry_t [num_fu-1:0] pick;

    ////////////////////
    // per-unit pick

    // lowest slot wins, so scan downwards
    always_comb begin
        sel_found = '0;
        sel_idx   = '0;
        for (int u = 0; u < num_fu; u++) begin
            for (int i = rs_depth - 1; i >= 0; i--) begin
                if (valid[i] && entries[i].src1.ready && entries[i].src2.ready
                        && (entries[i].fu == fu_idx_t'(u)) && fu_ready[u]) begin
                    sel_found[u] = 1'b1;
                    sel_idx[u]   = slot_idx_t'(i);
                end
            end
        end
    end

    always_comb begin
        clear = '0;
        for (int u = 0; u < num_fu; u++) begin
            pick[u] = entries[sel_idx[u]];
            if (sel_found[u]) begin
                clear[sel_idx[u]] = 1'b1;
            end
        end
    end

    ////////////////////
    // issue registers

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_valid <= '0;
        end else begin
            issue_valid <= sel_found;
        end
    end

    // payload held until the next issue on the lane
    always_ff @(posedge clk) begin
        for (int u = 0; u < num_fu; u++) begin
            if (sel_found[u]) begin
                issue_op[u]         <= pick[u].op;
                issue_rd[u]         <= pick[u].rd;
                issue_src1_value[u] <= pick[u].src1.value;
                issue_src2_value[u] <= pick[u].src2.value;
                issue_imm[u]        <= pick[u].imm;
                issue_rob_no[u]     <= pick[u].rob_no;
            end
        end
    end

endmodule

// ==== rtl/op_decoder.sv ====
`timescale 1ns/1ns

module op_decoder
    import rv_isa_pkg::*;
(
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    output op_t        op
);

    always_comb begin
        op = op_none;
        case (opcode)
            opcode_r: begin
                case (funct3)
                    f3_add:  op = op_add;
                    f3_xor:  op = op_xor;
                    default: op = op_none;
                endcase
            end
            opcode_i: begin
                case (funct3)
                    f3_addi: op = op_addi;
                    f3_srai: op = op_srai;
                    f3_ori:  op = op_ori;
                    default: op = op_none;
                endcase
            end
            // no funct3 on U-type
            opcode_lui: op = op_lui;
            opcode_load: begin
                case (funct3)
                    f3_lb:   op = op_lb;
                    f3_lw:   op = op_lw;
                    default: op = op_none;
                endcase
            end
            opcode_store: begin
                case (funct3)
                    f3_sb:   op = op_sb;
                    f3_sw:   op = op_sw;
                    default: op = op_none;
                endcase
            end
            default: op = op_none;
        endcase
    end

endmodule

// ==== rtl/rs_entry_array.sv ====
`timescale 1ns/1ns

module rs_entry_array
    import iq_cfg_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    rs_write_if.array                wr,
    input  logic [num_fu-1:0]        wb_valid,
    input  preg_t [num_fu-1:0]       wb_tag,
    input  word_t [num_fu-1:0]       wb_value,
    input  logic [rs_depth-1:0]      clear,
    output rs_entry_t [rs_depth-1:0] entries,
    output logic [rs_depth-1:0]      valid
);

    logic [rs_depth-1:0] slot_we;

    // one-hot decode of the write slot
    always_comb begin
        slot_we = '0;
        if (wr.we) begin
            slot_we[wr.slot] = 1'b1;
        end
    end

    ////////////////////
    // occupancy

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                if (slot_we[i]) begin
                    valid[i] <= 1'b1;
                end else if (clear[i]) begin
                    valid[i] <= 1'b0;
                end
            end
        end
    end

    assign wr.valid = valid;

    ////////////////////
    // slot payload

    // a fresh write already holds any same-cycle broadcast
    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (slot_we[i]) begin
                entries[i] <= wr.entry;
            end else if (valid[i]) begin
                entries[i].src1 <= wakeup(entries[i].src1, wb_valid, wb_tag, wb_value);
                entries[i].src2 <= wakeup(entries[i].src2, wb_valid, wb_tag, wb_value);
            end
        end
    end

endmodule

// ==== rtl/rs_write_if.sv ====
`timescale 1ns/1ns

interface rs_write_if
    import iq_cfg_pkg::*;
();

    // one slot write per cycle
    logic      we;
    slot_idx_t slot;
    rs_entry_t entry;

    // occupancy seen by the free-slot search
    logic [rs_depth-1:0] valid;

    modport ctrl (
        output we, slot, entry,
        input  valid
    );

    modport array (
        input  we, slot, entry,
        output valid
    );

endinterface

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // operation codes carried through the queue
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_add  = 4'd1,
        op_addi = 4'd2,
        op_lui  = 4'd3,
        op_ori  = 4'd4,
        op_xor  = 4'd5,
        op_srai = 4'd6,
        op_lb   = 4'd7,
        op_lw   = 4'd8,
        op_sb   = 4'd9,
        op_sw   = 4'd10
    } op_t;

    // major opcodes
    localparam logic [6:0] opcode_r     = 7'b0110011;
    localparam logic [6:0] opcode_i     = 7'b0010011;
    localparam logic [6:0] opcode_lui   = 7'b0110111;
    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    // funct3 selectors within each major opcode
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_addi = 3'b000;
    localparam logic [2:0] f3_srai = 3'b101;
    localparam logic [2:0] f3_ori  = 3'b110;
    localparam logic [2:0] f3_lb   = 3'b000;
    localparam logic [2:0] f3_lw   = 3'b010;
    localparam logic [2:0] f3_sb   = 3'b000;
    localparam logic [2:0] f3_sw   = 3'b010;

    function automatic logic uses_src1(op_t op);
        return op != op_lui;
    endfunction

    function automatic logic uses_src2(op_t op);
        return op inside {op_add, op_xor, op_sb, op_sw};
    endfunction

    function automatic logic is_mem_op(op_t op);
        return op inside {op_lb, op_lw, op_sb, op_sw};
    endfunction

endpackage

// ==== testbench/issue_queue_asserts.sv ====
`timescale 1ns/1ns

module issue_queue_asserts
    import rv_isa_pkg::*;
    import iq_cfg_pkg::*;
(
    input logic               clk,
    input logic               rstn,
    input logic [num_fu-1:0]  fu_ready,
    input logic [num_fu-1:0]  issue_valid,
    input op_t [num_fu-1:0]   issue_op,
    input word_t [num_fu-1:0] issue_src1_value,
    input logic               dispatch_full
);

    // load/store unit sees memory ops only
    mem_unit_only: assert property (@(posedge clk) disable iff (!rstn)
        issue_valid[fu_mem] |-> is_mem_op(issue_op[fu_mem]))
        else $error("non-memory op issued on the load/store unit");

    for (genvar u = 0; u < num_fu; u++) begin : g_unit
        if (u != fu_mem) begin : g_alu
            alu_unit_only: assert property (@(posedge clk) disable iff (!rstn)
                issue_valid[u] |-> !is_mem_op(issue_op[u]))
                else $error("memory op issued on alu unit %0d", u);
        end

        fu_ready_seen: assert property (@(posedge clk) disable iff (!rstn)
            issue_valid[u] |-> $past(fu_ready[u]))
            else $error("unit %0d issued while its fu_ready was low", u);

        // lui has no rs1 operand
        lui_src1_zero: assert property (@(posedge clk) disable iff (!rstn)
            (issue_valid[u] && issue_op[u] == op_lui) |-> issue_src1_value[u] == '0)
            else $error("lui on unit %0d carries a nonzero src1 value", u);
    end

    full_low_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !dispatch_full)
        else $error("dispatch_full high right after reset");

endmodule

bind issue_queue_top issue_queue_asserts issue_queue_asserts_i (
    .clk              (clk),
    .rstn             (rstn),
    .fu_ready         (fu_ready),
    .issue_valid      (issue_valid),
    .issue_op         (issue_op),
    .issue_src1_value (issue_src1_value),
    .dispatch_full    (dispatch_full)
);

// ==== testbench/tb_issue_queue.sv ====
`timescale 1ns/1ns

module tb_issue_queue
    import rv_isa_pkg::*;
    import iq_cfg_pkg::*;
();

    localparam int est_cycles = 150;
    // margin over the expected run length
    localparam int max_cycles = est_cycles * 2 + 100;

    typedef struct {
        int      unit;
        int      cyc;
        op_t     op;
        preg_t   rd;
        preg_t   tag2;
        word_t   src1;
        word_t   src2;
        word_t   imm;
        rob_no_t rob;
    } exp_t;

    logic                 clk;
    logic                 rstn;
    logic                 dispatch_valid;
    logic [6:0]           opcode;
    logic [2:0]           funct3;
    preg_t                rs1;
    word_t                rs1_value;
    preg_t                rs2;
    word_t                rs2_value;
    preg_t                rd;
    word_t                imm;
    logic [num_pregs-1:0] reg_ready;
    logic [num_fu-1:0]    fu_ready;
    logic [num_fu-1:0]    wb_valid;
    preg_t [num_fu-1:0]   wb_tag;
    word_t [num_fu-1:0]   wb_value;
    logic [num_fu-1:0]    issue_valid;
    op_t [num_fu-1:0]     issue_op;
    preg_t [num_fu-1:0]   issue_rd;
    word_t [num_fu-1:0]   issue_src1_value;
    word_t [num_fu-1:0]   issue_src2_value;
    word_t [num_fu-1:0]   issue_imm;
    rob_no_t [num_fu-1:0] issue_rob_no;
    logic                 dispatch_full;

    int          cyc = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          alu_unit = 0;
    rob_no_t     rob_model = '0;
    logic [15:0] lfsr_state = 16'd63759;
    exp_t        exp_q[$];

    issue_queue_top issue_queue_top_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles, %0d issues outstanding",
                     cyc, exp_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////
    // helpers

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic check_value(input string what, input int u, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want)
            else report_mismatch($sformatf("unit %0d %s is %0h, expected %0h",
                                           u, what, got, want));
    endtask

    task automatic check_issue(input exp_t e);
        assert (issue_valid[e.unit])
            else report_mismatch($sformatf("unit %0d did not issue rob %0d", e.unit, e.rob));
        check_value("op", e.unit, 32'(issue_op[e.unit]), 32'(e.op));
        check_value("rd", e.unit, 32'(issue_rd[e.unit]), 32'(e.rd));
        check_value("src1", e.unit, issue_src1_value[e.unit], e.src1);
        check_value("src2", e.unit, issue_src2_value[e.unit], e.src2);
        check_value("imm", e.unit, issue_imm[e.unit], e.imm);
        check_value("rob", e.unit, 32'(issue_rob_no[e.unit]), 32'(e.rob));
    endtask

    // every unit either matches a record due now or stays quiet
    task automatic check_outputs();
        int idx;
        for (int u = 0; u < num_fu; u++) begin
            idx = -1;
            foreach (exp_q[k]) begin
                if (exp_q[k].unit == u && exp_q[k].cyc == cyc) begin
                    idx = k;
                end
            end
            if (idx >= 0) begin
                check_issue(exp_q[idx]);
                exp_q.delete(idx);
            end else begin
                assert (!issue_valid[u])
                    else report_mismatch($sformatf("unit %0d issued rob %0d unexpectedly",
                                                   u, issue_rob_no[u]));
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        if (rstn) begin
            check_outputs();
        end
    endtask

    task automatic dispatch_instr(input logic [6:0] opc, input logic [2:0] f3, input op_t op,
                                  input logic src2_wait, input logic accept, output exp_t rec);
        logic [31:0] r;
        logic        mem;
        mem = (opc == opcode_load) || (opc == opcode_store);
        take_bits(6, r);
        rs1 = preg_t'(r);
        take_bits(6, r);
        rs2 = preg_t'(r);
        take_bits(6, r);
        rd = preg_t'(r);
        take_bits(32, rs1_value);
        take_bits(32, rs2_value);
        take_bits(32, imm);
        if (src2_wait) begin
            // rs1 on another tag, so only rs2 waits
            rs1 = ~rs2;
            reg_ready[rs2] = 1'b0;
        end
        opcode         = opc;
        funct3         = f3;
        dispatch_valid = 1'b1;
        rec.unit = mem ? 2 : alu_unit;
        rec.cyc  = cyc + 2;
        rec.op   = op;
        rec.rd   = rd;
        rec.tag2 = rs2;
        // lui reads no rs1, only R-type and stores read rs2
        rec.src1 = (opc == opcode_lui) ? '0 : rs1_value;
        rec.src2 = (opc == opcode_r || opc == opcode_store) ? rs2_value : '0;
        rec.imm  = imm;
        rec.rob  = rob_model;
        if (accept) begin
            rob_model = rob_model + 1'b1;
            if (!mem) begin
                alu_unit = 1 - alu_unit;
            end
        end
        step();
        dispatch_valid = 1'b0;
        reg_ready      = '1;
        assert (dispatch_full == !accept)
            else report_mismatch($sformatf("dispatch_full is %0b after dispatch", dispatch_full));
    endtask

    task automatic wait_for_drain();
        while (exp_q.size() != 0) begin
            step();
        end
        step();
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        $display("test %0d %s: %0d failed checks", tests_run, name, errors - err_before);
    endtask

    ////////////////////
    // tests

    initial begin
        exp_t rec;
        exp_t loads[rs_depth];
        int   err_before;
        clk            = 1'b0;
        rstn           = 1'b0;
        dispatch_valid = 1'b0;
        opcode         = '0;
        funct3         = '0;
        rs1            = '0;
        rs1_value      = '0;
        rs2            = '0;
        rs2_value      = '0;
        rd             = '0;
        imm            = '0;
        reg_ready      = '1;
        fu_ready       = '1;
        wb_valid       = '0;
        wb_tag         = '0;
        wb_value       = '0;
        repeat (2) step();
        rstn = 1'b1;

        err_before = errors;
        step();
        assert (issue_valid == '0) else report_mismatch("issue_valid high after reset");
        assert (!dispatch_full) else report_mismatch("dispatch_full high after reset");
        finish_test("reset", err_before);

        err_before = errors;
        dispatch_instr(opcode_r, f3_add, op_add, 1'b0, 1'b1, rec);
        exp_q.push_back(rec);
        dispatch_instr(opcode_load, f3_lw, op_lw, 1'b0, 1'b1, rec);
        exp_q.push_back(rec);
        dispatch_instr(opcode_r, f3_xor, op_xor, 1'b0, 1'b1, rec);
        exp_q.push_back(rec);
        dispatch_instr(opcode_i, f3_ori, op_ori, 1'b0, 1'b1, rec);
        exp_q.push_back(rec);
        dispatch_instr(opcode_store, f3_sw, op_sw, 1'b0, 1'b1, rec);
        exp_q.push_back(rec);
        wait_for_drain();
        finish_test("routing and round robin", err_before);

        err_before = errors;
        dispatch_instr(opcode_lui, 3'b000, op_lui, 1'b0, 1'b1, rec);
        exp_q.push_back(rec);
        dispatch_instr(opcode_i, f3_addi, op_addi, 1'b0, 1'b1, rec);
        exp_q.push_back(rec);
        dispatch_instr(opcode_load, f3_lb, op_lb, 1'b0, 1'b1, rec);
        exp_q.push_back(rec);
        dispatch_instr(opcode_i, f3_srai, op_srai, 1'b0, 1'b1, rec);
        exp_q.push_back(rec);
        wait_for_drain();
        finish_test("operand zeroing", err_before);

        // one waiting add per writeback lane
        err_before = errors;
        for (int lane = 0; lane < num_fu; lane++) begin
            dispatch_instr(opcode_r, f3_add, op_add, 1'b1, 1'b1, rec);
            repeat (3) step();
            take_bits(32, rec.src2);
            wb_valid[lane] = 1'b1;
            wb_tag[lane]   = rec.tag2;
            wb_value[lane] = rec.src2;
            rec.cyc        = cyc + 2;
            exp_q.push_back(rec);
            step();
            wb_valid = '0;
            wait_for_drain();
        end
        finish_test("wakeup", err_before);

        err_before = errors;
        fu_ready = 3'b011;
        for (int k = 0; k < rs_depth; k++) begin
            if (k % 2 == 0) begin
                dispatch_instr(opcode_load, f3_lw, op_lw, 1'b0, 1'b1, loads[k]);
            end else begin
                dispatch_instr(opcode_load, f3_lb, op_lb, 1'b0, 1'b1, loads[k]);
            end
        end
        // queue is full, this one is lost
        dispatch_instr(opcode_load, f3_lw, op_lw, 1'b0, 1'b0, rec);
        repeat (2) step();
        fu_ready = '1;
        for (int k = 0; k < rs_depth; k++) begin
            loads[k].cyc = cyc + 1 + k;
            exp_q.push_back(loads[k]);
        end
        wait_for_drain();
        // rob numbering skips nothing for the dropped load
        dispatch_instr(opcode_r, f3_xor, op_xor, 1'b0, 1'b1, rec);
        exp_q.push_back(rec);
        wait_for_drain();
        finish_test("per-unit blocking and full", err_before);

        $display("tests run: %0d, failed checks: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
